//--- all.f
logic/xbar_cfg_pkg.sv
logic/xbar_bus_pkg.sv
logic/addr_decode.sv
logic/req_demux.sv
logic/decerr_responder.sv
logic/req_mux.sv
logic/xbar_top.sv
tests/xbar_props.sv
tests/tb_xbar.sv

//--- Makefile
# Verilator build for the crossbar testbench

TOP = tb_xbar
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/tb_xbar.sv
// --------------------
// Crossbar testbench
// Random traffic from two initiators, two memory
// target models, in-order scoreboard and timeout
// --------------------
`timescale 1ns/1ps

module tb_xbar;

  import xbar_cfg_pkg::*;
  import xbar_bus_pkg::*;

  localparam int unsigned NUM_REQ = 200;
  localparam int unsigned TIMEOUT = 20000;  // About 25 times the nominal traffic length
  localparam int unsigned SEED    = 49287;

  logic clk_i;
  logic rst_n_i;

  init_req_t [NUM_INIT-1:0] init_req;
  logic      [NUM_INIT-1:0] init_req_valid, init_req_ready;
  init_rsp_t [NUM_INIT-1:0] init_rsp;
  logic      [NUM_INIT-1:0] init_rsp_valid, init_rsp_ready;
  tgt_req_t  [NUM_TGT-1:0]  tgt_req;
  logic      [NUM_TGT-1:0]  tgt_req_valid, tgt_req_ready;
  tgt_rsp_t  [NUM_TGT-1:0]  tgt_rsp;
  logic      [NUM_TGT-1:0]  tgt_rsp_valid, tgt_rsp_ready;

  // Issue history per initiator, indexed in issue order
  addr_t hist_addr  [NUM_INIT][NUM_REQ];
  logic  hist_write [NUM_INIT][NUM_REQ];
  id_t   hist_id    [NUM_INIT][NUM_REQ];
  logic  hist_map   [NUM_INIT][NUM_REQ];
  data_t exp_rd     [NUM_INIT][NUM_REQ];  // Filled when the target takes the request
  int    issued     [NUM_INIT];
  int    tgt_ptr    [NUM_INIT];
  int    rsp_ptr    [NUM_INIT];

  data_t    mem    [65536];               // Target model storage
  data_t    shadow [65536];               // Scoreboard copy
  tgt_rsp_t rsp_q  [NUM_TGT][$];
  int       due_q  [NUM_TGT][$];
  int       last_gnt [NUM_TGT];

  int cycle;
  int mismatches;
  int other_errors;

  xbar_top i_xbar_top (
    .clk_i            ( clk_i          ),
    .rst_n_i          ( rst_n_i        ),
    .init_req_i       ( init_req       ),
    .init_req_valid_i ( init_req_valid ),
    .init_req_ready_o ( init_req_ready ),
    .init_rsp_o       ( init_rsp       ),
    .init_rsp_valid_o ( init_rsp_valid ),
    .init_rsp_ready_i ( init_rsp_ready ),
    .tgt_req_o        ( tgt_req        ),
    .tgt_req_valid_o  ( tgt_req_valid  ),
    .tgt_req_ready_i  ( tgt_req_ready  ),
    .tgt_rsp_i        ( tgt_rsp        ),
    .tgt_rsp_valid_i  ( tgt_rsp_valid  ),
    .tgt_rsp_ready_o  ( tgt_rsp_ready  )
  );

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s got=%h exp=%h at cycle %0d", name, got, exp, cycle);
      mismatches++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %s at cycle %0d", msg, cycle);
    other_errors++;
  endtask

  function automatic logic all_done();
    return (rsp_ptr[0] == NUM_REQ) && (rsp_ptr[1] == NUM_REQ);
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  // Initiator stimulus and in-order response checks
  always @(posedge clk_i) begin
    init_req_t r;
    int        k;
    int        sel;
    if (rst_n_i) begin
      for (int i = 0; i < NUM_INIT; i++) begin
        if (init_rsp_valid[i] && init_rsp_ready[i]) begin
          k = rsp_ptr[i];
          if (k >= issued[i]) begin
            report_error("response without an issued request");
          end else begin
            check_value("init_rsp.id", init_rsp[i].id, hist_id[i][k]);
            check_value("init_rsp.err", init_rsp[i].err, !hist_map[i][k]);
            if (!hist_map[i][k]) begin
              check_value("init_rsp.rdata", init_rsp[i].rdata, '0);
            end else if (!hist_write[i][k]) begin
              check_value("init_rsp.rdata", init_rsp[i].rdata, exp_rd[i][k]);
            end
          end
          rsp_ptr[i]++;
        end
        if (!init_req_valid[i] || init_req_ready[i]) begin
          if (issued[i] < NUM_REQ && ($urandom % 4) != 0) begin
            sel = $urandom % 8;
            r.addr  = (sel < 3) ? 16'h0000 : (sel < 6) ? 16'h4000 :
                      (sel == 6) ? 16'h8000 : 16'hC000;
            r.addr  = r.addr | addr_t'(($urandom % 16) << 2);
            r.write = $urandom % 2;
            r.wdata = $urandom;
            r.id    = id_t'(issued[i]);
            hist_addr[i][issued[i]]  = r.addr;
            hist_write[i][issued[i]] = r.write;
            hist_id[i][issued[i]]    = r.id;
            hist_map[i][issued[i]]   = (r.addr < 16'h8000);
            issued[i]++;
            init_req[i]       <= r;
            init_req_valid[i] <= 1'b1;
          end else begin
            init_req_valid[i] <= 1'b0;
          end
        end
        init_rsp_ready[i] <= ($urandom % 4) != 0;
      end
    end
  end

  // Memory target models with random ready and 0 to 3 cycles of delay
  always @(posedge clk_i) begin
    tgt_req_t  r;
    tgt_rsp_t  p;
    int        i;
    int        k;
    if (rst_n_i) begin
      for (int j = 0; j < NUM_TGT; j++) begin
        if (tgt_req_valid[j] && tgt_req_ready[j]) begin
          r = tgt_req[j];
          i = int'(r.tgt_id[TGT_ID_W-1]);
          k = tgt_ptr[i];
          while (k < issued[i] && !hist_map[i][k]) k++;
          if (k >= issued[i]) begin
            report_error("target request without a matching initiator request");
          end else begin
            check_value("tgt_req.addr", r.addr, hist_addr[i][k]);
            check_value("tgt_req.region", r.addr[15:14], j);
            check_value("tgt_req.tgt_id", r.tgt_id[ID_W-1:0], hist_id[i][k]);
            exp_rd[i][k] = shadow[r.addr];
            if (r.write) shadow[r.addr] = r.wdata;
            tgt_ptr[i] = k + 1;
          end
          p.rdata  = r.write ? '0 : mem[r.addr];
          p.err    = 1'b0;
          p.tgt_id = r.tgt_id;
          if (r.write) mem[r.addr] = r.wdata;
          rsp_q[j].push_back(p);
          due_q[j].push_back(cycle + int'($urandom % 4));
        end
        if (tgt_rsp_valid[j] && tgt_rsp_ready[j]) begin
          void'(rsp_q[j].pop_front());
          void'(due_q[j].pop_front());
        end
        if (rsp_q[j].size() > 0 && due_q[j][0] <= cycle) begin
          tgt_rsp[j]       <= rsp_q[j][0];
          tgt_rsp_valid[j] <= 1'b1;
        end else begin
          tgt_rsp_valid[j] <= 1'b0;
        end
        tgt_req_ready[j] <= ($urandom % 4) != 0;
      end
    end
  end

  // Round robin, with both inputs valid the grant goes to the other one
  always @(posedge clk_i) begin
    logic [NUM_INIT-1:0] v;
    logic [NUM_INIT-1:0] g;
    if (rst_n_i) begin
      for (int j = 0; j < NUM_TGT; j++) begin
        v = i_xbar_top.mux_req_valid[j];
        g = i_xbar_top.mux_req_ready[j] & v;
        if (g != '0) begin
          if (&v) check_value("mux grant", g[1], last_gnt[j] == 0);
          last_gnt[j] = g[1] ? 1 : 0;
        end
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    rst_n_i        <= 1'b0;
    init_req       <= '0;
    init_req_valid <= '0;
    init_rsp_ready <= '0;
    tgt_req_ready  <= '0;
    tgt_rsp        <= '0;
    tgt_rsp_valid  <= '0;
    cycle        = 0;
    mismatches   = 0;
    other_errors = 0;
    for (int i = 0; i < NUM_INIT; i++) begin
      issued[i]  = 0;
      tgt_ptr[i] = 0;
      rsp_ptr[i] = 0;
    end
    for (int j = 0; j < NUM_TGT; j++) last_gnt[j] = 1;   // Pointer starts at initiator 0
    for (int a = 0; a < 65536; a++) begin
      mem[a]    = '0;
      shadow[a] = '0;
    end
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    while (!all_done() && cycle < TIMEOUT) @(posedge clk_i);
    if (!all_done()) report_error("timeout, not all responses arrived");
    $display("Errors: mismatches=%0d other=%0d assertions=%0d", mismatches, other_errors,
             i_xbar_top.i_xbar_props.fail_count);
    if (mismatches == 0 && other_errors == 0 &&
        i_xbar_top.i_xbar_props.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- tests/xbar_props.sv
// --------------------
// Crossbar properties
// Handshake stability, reset state and
// request latency through the mux register
// --------------------
`timescale 1ns/1ps

module xbar_props (
  input logic                                                 clk_i,
  input logic                                                 rst_n_i,
  input xbar_bus_pkg::init_req_t [xbar_cfg_pkg::NUM_INIT-1:0] init_req_i,
  input logic                    [xbar_cfg_pkg::NUM_INIT-1:0] init_req_valid_i,
  input logic                    [xbar_cfg_pkg::NUM_INIT-1:0] init_req_ready_o,
  input xbar_bus_pkg::init_rsp_t [xbar_cfg_pkg::NUM_INIT-1:0] init_rsp_o,
  input logic                    [xbar_cfg_pkg::NUM_INIT-1:0] init_rsp_valid_o,
  input logic                    [xbar_cfg_pkg::NUM_INIT-1:0] init_rsp_ready_i,
  input xbar_bus_pkg::tgt_req_t  [xbar_cfg_pkg::NUM_TGT-1:0]  tgt_req_o,
  input logic                    [xbar_cfg_pkg::NUM_TGT-1:0]  tgt_req_valid_o,
  input logic                    [xbar_cfg_pkg::NUM_TGT-1:0]  tgt_req_ready_i,
  input xbar_bus_pkg::tgt_rsp_t  [xbar_cfg_pkg::NUM_TGT-1:0]  tgt_rsp_i,
  input logic                    [xbar_cfg_pkg::NUM_TGT-1:0]  tgt_rsp_valid_i,
  input logic                    [xbar_cfg_pkg::NUM_TGT-1:0]  tgt_rsp_ready_o
);

  import xbar_cfg_pkg::*;

  int unsigned fail_count = 0;   // Failed assertions so far

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_init
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      init_req_valid_i[i] && !init_req_ready_o[i] |=>
        init_req_valid_i[i] && $stable(init_req_i[i]))
      else begin
        $error("initiator request not held");
        fail_count++;
      end
    a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      init_rsp_valid_o[i] && !init_rsp_ready_i[i] |=>
        init_rsp_valid_o[i] && $stable(init_rsp_o[i]))
      else begin
        $error("initiator response not held");
        fail_count++;
      end
    a_rsp_reset: assert property (@(posedge clk_i) !rst_n_i |=> !init_rsp_valid_o[i])
      else begin
        $error("initiator response valid after reset");
        fail_count++;
      end

    // Empty mux register forwards the request in the next cycle
    for (genvar j = 0; j < NUM_TGT; j++) begin : gen_tgt
      a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        init_req_valid_i[i] && init_req_ready_o[i] && !tgt_req_valid_o[j] &&
        ((init_req_i[i].addr & TGT_MASK[j]) == TGT_BASE[j]) |=>
          tgt_req_valid_o[j] &&
          (tgt_req_o[j].tgt_id == {1'(i), $past(init_req_i[i].id)}))
        else begin
          $error("target request not one cycle after transfer");
          fail_count++;
        end
    end
  end

  for (genvar j = 0; j < NUM_TGT; j++) begin : gen_tgt_side
    a_tgt_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tgt_req_valid_o[j] && !tgt_req_ready_i[j] |=>
        tgt_req_valid_o[j] && $stable(tgt_req_o[j]))
      else begin
        $error("target request not held");
        fail_count++;
      end
    a_tgt_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tgt_rsp_valid_i[j] && !tgt_rsp_ready_o[j] |=>
        tgt_rsp_valid_i[j] && $stable(tgt_rsp_i[j]))
      else begin
        $error("target response not held");
        fail_count++;
      end
    a_tgt_reset: assert property (@(posedge clk_i) !rst_n_i |=> !tgt_req_valid_o[j])
      else begin
        $error("target request valid after reset");
        fail_count++;
      end
  end

endmodule

bind xbar_top xbar_props i_xbar_props (.*);

//--- logic/xbar_top.sv
// --------------------
// Crossbar top
// Per initiator a decoder, demux and error responder,
// per target a mux, fully cross connected
// --------------------
`timescale 1ns/1ps

module xbar_top (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  xbar_bus_pkg::init_req_t [xbar_cfg_pkg::NUM_INIT-1:0] init_req_i,
  input  logic                    [xbar_cfg_pkg::NUM_INIT-1:0] init_req_valid_i,
  output logic                    [xbar_cfg_pkg::NUM_INIT-1:0] init_req_ready_o,
  output xbar_bus_pkg::init_rsp_t [xbar_cfg_pkg::NUM_INIT-1:0] init_rsp_o,
  output logic                    [xbar_cfg_pkg::NUM_INIT-1:0] init_rsp_valid_o,
  input  logic                    [xbar_cfg_pkg::NUM_INIT-1:0] init_rsp_ready_i,
  output xbar_bus_pkg::tgt_req_t  [xbar_cfg_pkg::NUM_TGT-1:0]  tgt_req_o,
  output logic                    [xbar_cfg_pkg::NUM_TGT-1:0]  tgt_req_valid_o,
  input  logic                    [xbar_cfg_pkg::NUM_TGT-1:0]  tgt_req_ready_i,
  input  xbar_bus_pkg::tgt_rsp_t  [xbar_cfg_pkg::NUM_TGT-1:0]  tgt_rsp_i,
  input  logic                    [xbar_cfg_pkg::NUM_TGT-1:0]  tgt_rsp_valid_i,
  output logic                    [xbar_cfg_pkg::NUM_TGT-1:0]  tgt_rsp_ready_o
);

  import xbar_cfg_pkg::*;
  import xbar_bus_pkg::*;

  // Demux side, last index is the error responder
  init_req_t [NUM_INIT-1:0][NUM_TGT:0] dmx_req;
  logic      [NUM_INIT-1:0][NUM_TGT:0] dmx_req_valid, dmx_req_ready;
  init_rsp_t [NUM_INIT-1:0][NUM_TGT:0] dmx_rsp;
  logic      [NUM_INIT-1:0][NUM_TGT:0] dmx_rsp_valid, dmx_rsp_ready;

  // Mux side
  init_req_t [NUM_TGT-1:0][NUM_INIT-1:0] mux_req;
  logic      [NUM_TGT-1:0][NUM_INIT-1:0] mux_req_valid, mux_req_ready;
  init_rsp_t [NUM_TGT-1:0][NUM_INIT-1:0] mux_rsp;
  logic      [NUM_TGT-1:0][NUM_INIT-1:0] mux_rsp_valid, mux_rsp_ready;

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_init
    sel_t sel;

    addr_decode i_addr_decode (
      .addr_i ( init_req_i[i].addr ),
      .sel_o  ( sel                )
    );

    req_demux i_req_demux (
      .clk_i           ( clk_i               ),
      .rst_n_i         ( rst_n_i             ),
      .req_i           ( init_req_i[i]       ),
      .req_valid_i     ( init_req_valid_i[i] ),
      .req_ready_o     ( init_req_ready_o[i] ),
      .sel_i           ( sel                 ),
      .rsp_o           ( init_rsp_o[i]       ),
      .rsp_valid_o     ( init_rsp_valid_o[i] ),
      .rsp_ready_i     ( init_rsp_ready_i[i] ),
      .mst_req_o       ( dmx_req[i]          ),
      .mst_req_valid_o ( dmx_req_valid[i]    ),
      .mst_req_ready_i ( dmx_req_ready[i]    ),
      .mst_rsp_i       ( dmx_rsp[i]          ),
      .mst_rsp_valid_i ( dmx_rsp_valid[i]    ),
      .mst_rsp_ready_o ( dmx_rsp_ready[i]    )
    );

    decerr_responder i_decerr_responder (
      .clk_i       ( clk_i                     ),
      .rst_n_i     ( rst_n_i                   ),
      .req_i       ( dmx_req[i][NUM_TGT]       ),
      .req_valid_i ( dmx_req_valid[i][NUM_TGT] ),
      .req_ready_o ( dmx_req_ready[i][NUM_TGT] ),
      .rsp_o       ( dmx_rsp[i][NUM_TGT]       ),
      .rsp_valid_o ( dmx_rsp_valid[i][NUM_TGT] ),
      .rsp_ready_i ( dmx_rsp_ready[i][NUM_TGT] )
    );
  end

  // Cross every initiator with every target
  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_cross_init
    for (genvar j = 0; j < NUM_TGT; j++) begin : gen_cross_tgt
      assign mux_req[j][i]       = dmx_req[i][j];
      assign mux_req_valid[j][i] = dmx_req_valid[i][j];
      assign dmx_req_ready[i][j] = mux_req_ready[j][i];
      assign dmx_rsp[i][j]       = mux_rsp[j][i];
      assign dmx_rsp_valid[i][j] = mux_rsp_valid[j][i];
      assign mux_rsp_ready[j][i] = dmx_rsp_ready[i][j];
    end
  end

  for (genvar j = 0; j < NUM_TGT; j++) begin : gen_tgt
    req_mux i_req_mux (
      .clk_i           ( clk_i              ),
      .rst_n_i         ( rst_n_i            ),
      .slv_req_i       ( mux_req[j]         ),
      .slv_req_valid_i ( mux_req_valid[j]   ),
      .slv_req_ready_o ( mux_req_ready[j]   ),
      .slv_rsp_o       ( mux_rsp[j]         ),
      .slv_rsp_valid_o ( mux_rsp_valid[j]   ),
      .slv_rsp_ready_i ( mux_rsp_ready[j]   ),
      .tgt_req_o       ( tgt_req_o[j]       ),
      .tgt_req_valid_o ( tgt_req_valid_o[j] ),
      .tgt_req_ready_i ( tgt_req_ready_i[j] ),
      .tgt_rsp_i       ( tgt_rsp_i[j]       ),
      .tgt_rsp_valid_i ( tgt_rsp_valid_i[j] ),
      .tgt_rsp_ready_o ( tgt_rsp_ready_o[j] )
    );
  end

endmodule

//--- logic/req_mux.sv
// --------------------
// Request multiplexer
// Round robin over the initiators into one output
// register, response routed back by ID prefix
// --------------------
`timescale 1ns/1ps

module req_mux (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  xbar_bus_pkg::init_req_t [xbar_cfg_pkg::NUM_INIT-1:0] slv_req_i,
  input  logic                    [xbar_cfg_pkg::NUM_INIT-1:0] slv_req_valid_i,
  output logic                    [xbar_cfg_pkg::NUM_INIT-1:0] slv_req_ready_o,
  output xbar_bus_pkg::init_rsp_t [xbar_cfg_pkg::NUM_INIT-1:0] slv_rsp_o,
  output logic                    [xbar_cfg_pkg::NUM_INIT-1:0] slv_rsp_valid_o,
  input  logic                    [xbar_cfg_pkg::NUM_INIT-1:0] slv_rsp_ready_i,
  output xbar_bus_pkg::tgt_req_t                               tgt_req_o,
  output logic                                                 tgt_req_valid_o,
  input  logic                                                 tgt_req_ready_i,
  input  xbar_bus_pkg::tgt_rsp_t                               tgt_rsp_i,
  input  logic                                                 tgt_rsp_valid_i,
  output logic                                                 tgt_rsp_ready_o
);

  import xbar_cfg_pkg::*;
  import xbar_bus_pkg::*;

  logic [INIT_IDX_W-1:0] rr_q;       // First initiator to look at
  logic [INIT_IDX_W-1:0] gnt_idx;
  logic                  gnt_valid;
  logic                  load;
  logic                  out_valid_q;
  tgt_req_t              out_q;
  logic [INIT_IDX_W-1:0] rsp_idx;

  // Search starts at the pointer and wraps around
  always_comb begin : rr_arbiter
    logic [INIT_IDX_W-1:0] cand;
    gnt_valid = 1'b0;
    gnt_idx   = rr_q;
    for (int k = NUM_INIT - 1; k >= 0; k--) begin
      cand = INIT_IDX_W'((int'(rr_q) + k) % NUM_INIT);
      if (slv_req_valid_i[cand]) begin
        gnt_valid = 1'b1;
        gnt_idx   = cand;
      end
    end
  end

  // Register can refill in the cycle it drains
  assign load = !out_valid_q || tgt_req_ready_i;

  always_comb begin
    for (int i = 0; i < NUM_INIT; i++) begin
      slv_req_ready_o[i] = load && gnt_valid && (gnt_idx == INIT_IDX_W'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
      rr_q        <= '0;
    end else if (load) begin
      out_valid_q <= gnt_valid;
      if (gnt_valid) begin
        rr_q <= (gnt_idx == INIT_IDX_W'(NUM_INIT - 1)) ? '0 : gnt_idx + 1'b1;
      end
    end
  end

  // Winner index goes in front of the original ID
  always_ff @(posedge clk_i) begin
    if (load && gnt_valid) begin
      out_q.addr   <= slv_req_i[gnt_idx].addr;
      out_q.write  <= slv_req_i[gnt_idx].write;
      out_q.wdata  <= slv_req_i[gnt_idx].wdata;
      out_q.tgt_id <= {gnt_idx, slv_req_i[gnt_idx].id};
    end
  end

  assign tgt_req_o       = out_q;
  assign tgt_req_valid_o = out_valid_q;

  assign rsp_idx = tgt_rsp_i.tgt_id[TGT_ID_W-1 -: INIT_IDX_W];

  always_comb begin
    for (int i = 0; i < NUM_INIT; i++) begin
      slv_rsp_o[i].rdata = tgt_rsp_i.rdata;
      slv_rsp_o[i].err   = tgt_rsp_i.err;
      slv_rsp_o[i].id    = tgt_rsp_i.tgt_id[ID_W-1:0];   // prefix stripped
      slv_rsp_valid_o[i] = tgt_rsp_valid_i && (rsp_idx == INIT_IDX_W'(i));
    end
  end

  assign tgt_rsp_ready_o = slv_rsp_ready_i[rsp_idx];

endmodule

//--- logic/decerr_responder.sv
// --------------------
// Decode error responder
// Ends unmapped requests with an error
// response that carries the request ID
// --------------------
`timescale 1ns/1ps

module decerr_responder (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  xbar_bus_pkg::init_req_t req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  output xbar_bus_pkg::init_rsp_t rsp_o,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i
);

  import xbar_bus_pkg::*;

  logic busy_q;   // Holds one response
  id_t  id_q;

  assign req_ready_o = !busy_q;
  assign rsp_valid_o = busy_q;

  always_comb begin
    rsp_o.rdata = '0;
    rsp_o.err   = 1'b1;
    rsp_o.id    = id_q;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      busy_q <= 1'b1;
    end else if (busy_q && rsp_ready_i) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      id_q <= req_i.id;                    // only the ID is echoed back
    end
  end

endmodule

//--- logic/req_demux.sv
// --------------------
// Request demultiplexer
// Steers one initiator onto a target or the error
// responder and keeps its responses in order
// --------------------
`timescale 1ns/1ps

module req_demux (
  input  logic                                               clk_i,
  input  logic                                               rst_n_i,
  input  xbar_bus_pkg::init_req_t                            req_i,
  input  logic                                               req_valid_i,
  output logic                                               req_ready_o,
  input  xbar_bus_pkg::sel_t                                 sel_i,
  output xbar_bus_pkg::init_rsp_t                            rsp_o,
  output logic                                               rsp_valid_o,
  input  logic                                               rsp_ready_i,
  output xbar_bus_pkg::init_req_t [xbar_cfg_pkg::NUM_TGT:0] mst_req_o,
  output logic                    [xbar_cfg_pkg::NUM_TGT:0] mst_req_valid_o,
  input  logic                    [xbar_cfg_pkg::NUM_TGT:0] mst_req_ready_i,
  input  xbar_bus_pkg::init_rsp_t [xbar_cfg_pkg::NUM_TGT:0] mst_rsp_i,
  input  logic                    [xbar_cfg_pkg::NUM_TGT:0] mst_rsp_valid_i,
  output logic                    [xbar_cfg_pkg::NUM_TGT:0] mst_rsp_ready_o
);

  import xbar_cfg_pkg::*;
  import xbar_bus_pkg::*;

  logic [CNT_W-1:0] cnt_q, cnt_d;   // Outstanding requests
  sel_t             sel_q;          // Destination of the outstanding requests
  logic             stall;
  logic             req_fire;
  logic             rsp_fire;

  // A switch of destination waits until everything pending has returned
  assign stall = (cnt_q == CNT_W'(MAX_TRANS)) ||
                 ((cnt_q != '0) && (sel_i != sel_q));

  assign req_ready_o = !stall && mst_req_ready_i[sel_i];
  assign req_fire    = req_valid_i && req_ready_o;

  always_comb begin
    for (int k = 0; k <= NUM_TGT; k++) begin
      mst_req_o[k]       = req_i;           // payload fans out, valid selects
      mst_req_valid_o[k] = req_valid_i && !stall && (sel_i == sel_t'(k));
    end
  end

  // Responses only come from where the pending requests went
  assign rsp_o       = mst_rsp_i[sel_q];
  assign rsp_valid_o = mst_rsp_valid_i[sel_q] && (cnt_q != '0);
  assign rsp_fire    = rsp_valid_o && rsp_ready_i;

  always_comb begin
    for (int k = 0; k <= NUM_TGT; k++) begin
      mst_rsp_ready_o[k] = rsp_ready_i && (cnt_q != '0) && (sel_q == sel_t'(k));
    end
  end

  always_comb begin
    cnt_d = cnt_q;
    case ({req_fire, rsp_fire})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;              // none, or one in and one out
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      sel_q <= '0;
    end else begin
      cnt_q <= cnt_d;
      if (req_fire) begin
        sel_q <= sel_i;
      end
    end
  end

endmodule

//--- logic/addr_decode.sv
// --------------------
// Address decoder
// Maps a request address to a target index,
// or to the error responder when no region matches
// --------------------
`timescale 1ns/1ps

module addr_decode (
  input  xbar_bus_pkg::addr_t addr_i,
  output xbar_bus_pkg::sel_t  sel_o
);

  import xbar_cfg_pkg::*;
  import xbar_bus_pkg::*;

  logic [NUM_TGT-1:0] hit;

  // One comparator per region
  always_comb begin
    for (int t = 0; t < NUM_TGT; t++) begin
      hit[t] = ((addr_i & TGT_MASK[t]) == TGT_BASE[t]);
    end
  end

  // Lowest matching index wins, regions do not overlap anyway
  always_comb begin
    sel_o = sel_t'(NUM_TGT);               // default is decode error
    for (int t = NUM_TGT - 1; t >= 0; t--) begin
      if (hit[t]) begin
        sel_o = sel_t'(t);
      end
    end
  end

endmodule

//--- logic/xbar_bus_pkg.sv
// --------------------
// Crossbar bus types
// Field vectors and the request and response
// payloads on initiator and target side
// --------------------
package xbar_bus_pkg;

  import xbar_cfg_pkg::*;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [ID_W-1:0]     id_t;
  typedef logic [TGT_ID_W-1:0] tgt_id_t;
  typedef logic [SEL_W-1:0]    sel_t;    // NUM_TGT selects the error responder

  // Initiator side, original ID
  typedef struct packed {
    addr_t addr;
    logic  write;
    data_t wdata;
    id_t   id;
  } init_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
    id_t   id;
  } init_rsp_t;

  // Target side, ID widened with the initiator index
  typedef struct packed {
    addr_t   addr;
    logic    write;
    data_t   wdata;
    tgt_id_t tgt_id;
  } tgt_req_t;

  typedef struct packed {
    data_t   rdata;
    logic    err;
    tgt_id_t tgt_id;
  } tgt_rsp_t;

endpackage

//--- logic/xbar_cfg_pkg.sv
// --------------------
// Crossbar configuration
// Port counts, field widths, outstanding limit
// and the fixed target address map
// --------------------
package xbar_cfg_pkg;

  localparam int unsigned NUM_INIT  = 2;
  localparam int unsigned NUM_TGT   = 2;

  localparam int unsigned ADDR_W    = 16;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned ID_W      = 2;

  // Initiator index carried in the upper ID bits at the target side
  localparam int unsigned INIT_IDX_W = $clog2(NUM_INIT);
  localparam int unsigned TGT_ID_W   = ID_W + INIT_IDX_W;

  // One extra select value addresses the decode error responder
  localparam int unsigned SEL_W     = $clog2(NUM_TGT + 1);

  localparam int unsigned MAX_TRANS = 4;
  localparam int unsigned CNT_W     = $clog2(MAX_TRANS + 1);

  // Target 0 covers 0x0000 to 0x3FFF
  localparam logic [ADDR_W-1:0] TGT0_BASE = 16'h0000;
  localparam logic [ADDR_W-1:0] TGT0_MASK = 16'hC000;
  // Target 1 covers 0x4000 to 0x7FFF
  localparam logic [ADDR_W-1:0] TGT1_BASE = 16'h4000;
  localparam logic [ADDR_W-1:0] TGT1_MASK = 16'hC000;

  // Indexed views of the map for the decoder loop
  localparam logic [NUM_TGT-1:0][ADDR_W-1:0] TGT_BASE = {TGT1_BASE, TGT0_BASE};
  localparam logic [NUM_TGT-1:0][ADDR_W-1:0] TGT_MASK = {TGT1_MASK, TGT0_MASK};

endpackage
